/* fib_consts.svh */
`ifndef FIB_CONSTS_SVH
`define FIB_CONSTS_SVH

// Name geometry on the wire and in the table
`define FIB_NAME_BITS 64
`define FIB_NAME_BYTES 8

// Prefix length field, carried in metadata bits 5:0
`define FIB_LEN_BITS 6

// Hash slot index width and slots per length
`define FIB_HASH_BITS 10
`define FIB_SLOTS 1024

// One bitmap row per possible prefix length
`define FIB_LENGTHS 64

// Outgoing frame: metadata, full name, matched prefix
`define FIB_FRAME_BYTES 17

// Metadata bit set on interest packets, clear on data packets
`define FIB_INTEREST_BIT 7

`endif

/* fib_pkg.sv */
`include "fib_consts.svh"

package fib_pkg;

    // Bus and header types
    typedef logic [`FIB_NAME_BITS-1:0] name_t;
    typedef logic [7:0] meta_t;
    typedef logic [7:0] byte_t;
    typedef logic [`FIB_LEN_BITS-1:0] plen_t;
    typedef logic [`FIB_HASH_BITS-1:0] hash_t;

    // Packet parser states
    typedef enum logic [1:0] {
        ING_IDLE,
        ING_META,
        ING_NAME
    } ingress_state_t;

    // Longest-prefix search states
    typedef enum logic [1:0] {
        LKP_IDLE,
        LKP_PROBE,
        LKP_WAIT,
        LKP_DONE
    } lookup_state_t;

    // Keep only the bits below len, length 0 gives an empty prefix
    function automatic name_t mask_name(name_t name, plen_t len);
        name_t keep;
        keep = (name_t'(1) << len) - name_t'(1);
        return name & keep;
    endfunction

    // Fold the masked name into a slot index
    function automatic hash_t fib_hash(name_t name, plen_t len);
        name_t masked;
        hash_t h;
        masked = mask_name(name, len);
        h = '0;
        // Full 10-bit slices from bit 0 upward
        for (int i = 0; i < `FIB_NAME_BITS / `FIB_HASH_BITS; i++) begin
            h ^= masked[i*`FIB_HASH_BITS +: `FIB_HASH_BITS];
        end
        // Leftover top bits, zero-extended
        h ^= hash_t'(masked >> ((`FIB_NAME_BITS / `FIB_HASH_BITS) * `FIB_HASH_BITS));
        return h;
    endfunction

endpackage

/* fib_arbiter.sv */
`timescale 1ns/10ps

module fib_arbiter (
    input  logic            inst_req,
    input  fib_pkg::plen_t  inst_len,
    input  fib_pkg::hash_t  inst_hash,
    input  logic            rd_req,
    input  fib_pkg::plen_t  rd_len,
    input  fib_pkg::hash_t  rd_hash,
    output logic            inst_gnt,
    output logic            rd_gnt,
    output logic            mem_we,
    output logic            mem_re,
    output fib_pkg::plen_t  mem_len,
    output fib_pkg::hash_t  mem_hash
);

    // Install always wins, it lasts one cycle so a read waits at most one
    assign inst_gnt = inst_req;
    assign rd_gnt   = rd_req && !inst_req;

    // Granted access becomes the memory command
    assign mem_we = inst_gnt;
    assign mem_re = rd_gnt;

    // Winner's address onto the single port
    always_comb begin
        if (inst_gnt) begin
            mem_len  = inst_len;
            mem_hash = inst_hash;
        end else begin
            mem_len  = rd_len;
            mem_hash = rd_hash;
        end
    end

endmodule

/* fib_bitmap.sv */
`timescale 1ns/10ps
`include "fib_consts.svh"

module fib_bitmap (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_we,
    input  logic            mem_re,
    input  fib_pkg::plen_t  mem_len,
    input  fib_pkg::hash_t  mem_hash,
    output logic            mem_rd_valid,
    output logic            mem_rd_bit
);

    // One row of slot bits per prefix length
    logic [`FIB_SLOTS-1:0] valid_bits [`FIB_LENGTHS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Empty table
            for (int i = 0; i < `FIB_LENGTHS; i++) begin
                valid_bits[i] <= '0;
            end
            mem_rd_valid <= 1'b0;
        end else begin
            // Install only ever sets a bit
            if (mem_we) begin
                valid_bits[mem_len][mem_hash] <= 1'b1;
            end
            mem_rd_valid <= mem_re;
        end
    end

    // Registered read, result lands with mem_rd_valid
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rd_bit <= valid_bits[mem_len][mem_hash];
        end
    end

endmodule

/* fib_ingress.sv */
`timescale 1ns/10ps
`include "fib_consts.svh"

module fib_ingress (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx_valid,
    input  fib_pkg::byte_t  data_spi_to_fib,
    input  logic            inst_gnt,
    output logic            prefix_ready,
    output fib_pkg::name_t  pit_out_prefix,
    output fib_pkg::meta_t  pit_out_metadata,
    output logic            inst_req,
    output fib_pkg::plen_t  inst_len,
    output fib_pkg::hash_t  inst_hash
);

    fib_pkg::ingress_state_t state;
    logic [2:0]              byte_cnt;
    fib_pkg::meta_t          meta_q;
    fib_pkg::name_t          name_sr;
    fib_pkg::name_t          name_full;
    logic                    last_byte;
    logic                    is_interest;

    // Name as it stands once the current byte is shifted in
    assign name_full = {name_sr[`FIB_NAME_BITS-9:0], data_spi_to_fib};

    // Eighth name byte on the bus this cycle
    assign last_byte = rx_valid && (state == fib_pkg::ING_NAME) && (byte_cnt == '0);
    assign is_interest = meta_q[`FIB_INTEREST_BIT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fib_pkg::ING_IDLE;
            byte_cnt     <= '0;
            prefix_ready <= 1'b0;
            inst_req     <= 1'b0;
        end else begin
            // PIT strobe lasts a single cycle
            prefix_ready <= 1'b0;
            // Arbiter answers in the same cycle
            if (inst_gnt) begin
                inst_req <= 1'b0;
            end
            case (state)
                fib_pkg::ING_IDLE: begin
                    // First valid byte of a packet is the metadata
                    if (rx_valid) begin
                        byte_cnt <= 3'(`FIB_NAME_BYTES - 1);
                        state    <= fib_pkg::ING_META;
                    end
                end
                fib_pkg::ING_META, fib_pkg::ING_NAME: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt - 3'd1;
                        state    <= fib_pkg::ING_NAME;
                        if (byte_cnt == '0) begin
                            state <= fib_pkg::ING_IDLE;
                            // Interests go to the PIT, data installs a prefix
                            if (is_interest) begin
                                prefix_ready <= 1'b1;
                            end else begin
                                inst_req <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= fib_pkg::ING_IDLE;
            endcase
        end
    end

    // Packet fields and outputs toward PIT and arbiter
    always_ff @(posedge clk) begin
        if (rx_valid && (state == fib_pkg::ING_IDLE)) begin
            meta_q <= data_spi_to_fib;
        end
        // MSB first, so older bytes move up
        if (rx_valid && (state != fib_pkg::ING_IDLE)) begin
            name_sr <= name_full;
        end
        if (last_byte && is_interest) begin
            pit_out_prefix   <= name_full;
            pit_out_metadata <= meta_q;
        end
        if (last_byte && !is_interest) begin
            inst_len  <= meta_q[`FIB_LEN_BITS-1:0];
            inst_hash <= fib_pkg::fib_hash(name_full, meta_q[`FIB_LEN_BITS-1:0]);
        end
    end

endmodule

/* fib_lookup.sv */
`timescale 1ns/10ps
`include "fib_consts.svh"

module fib_lookup (
    input  logic            clk,
    input  logic            rst,
    input  logic            fib_out,
    input  fib_pkg::name_t  pit_in_prefix,
    input  fib_pkg::meta_t  pit_in_metadata,
    input  logic            rd_gnt,
    input  logic            mem_rd_valid,
    input  logic            mem_rd_bit,
    input  logic            tx_busy,
    output logic            rd_req,
    output fib_pkg::plen_t  rd_len,
    output fib_pkg::hash_t  rd_hash,
    output logic            tx_start,
    output fib_pkg::meta_t  tx_meta,
    output fib_pkg::name_t  tx_name,
    output fib_pkg::name_t  tx_match
);

    fib_pkg::lookup_state_t state;
    fib_pkg::plen_t         cur_len;
    fib_pkg::name_t         lat_name;
    fib_pkg::meta_t         lat_meta;
    logic                   accept;
    logic                   search_end;

    // New request only when both the engine and the frame sender are free
    assign accept = (state == fib_pkg::LKP_IDLE) && fib_out && !tx_busy;

    // Registered bit is back, stop on a hit or on the empty prefix
    assign search_end = (state == fib_pkg::LKP_WAIT) && mem_rd_valid &&
                        (mem_rd_bit || (cur_len == '0));

    // Probe address for the current length
    assign rd_req  = (state == fib_pkg::LKP_PROBE);
    assign rd_len  = cur_len;
    assign rd_hash = fib_pkg::fib_hash(lat_name, cur_len);

    // Result stays stable through DONE, where the sender samples it
    assign tx_start = (state == fib_pkg::LKP_DONE);
    assign tx_meta  = {lat_meta[7:`FIB_LEN_BITS], cur_len};
    assign tx_name  = lat_name;
    assign tx_match = fib_pkg::mask_name(lat_name, cur_len);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= fib_pkg::LKP_IDLE;
            cur_len <= '0;
        end else begin
            case (state)
                fib_pkg::LKP_IDLE: begin
                    // Start at the requested length
                    if (accept) begin
                        cur_len <= pit_in_metadata[`FIB_LEN_BITS-1:0];
                        state   <= fib_pkg::LKP_PROBE;
                    end
                end
                fib_pkg::LKP_PROBE: begin
                    // Held until the arbiter lets the read through
                    if (rd_gnt) begin
                        state <= fib_pkg::LKP_WAIT;
                    end
                end
                fib_pkg::LKP_WAIT: begin
                    if (search_end) begin
                        state <= fib_pkg::LKP_DONE;
                    end else if (mem_rd_valid) begin
                        // Miss, one bit shorter
                        cur_len <= cur_len - 1'b1;
                        state   <= fib_pkg::LKP_PROBE;
                    end
                end
                fib_pkg::LKP_DONE: state <= fib_pkg::LKP_IDLE;
                default: state <= fib_pkg::LKP_IDLE;
            endcase
        end
    end

    // Request fields, held for the whole search
    always_ff @(posedge clk) begin
        if (accept) begin
            lat_name <= pit_in_prefix;
            lat_meta <= pit_in_metadata;
        end
    end

    // Search only ever walks toward shorter prefixes
    a_len_monotonic: assert property (@(posedge clk) disable iff (rst)
        (state != fib_pkg::LKP_IDLE) |=> (cur_len <= $past(cur_len)));

endmodule

/* fib_spi_tx.sv */
`timescale 1ns/10ps
`include "fib_consts.svh"

module fib_spi_tx (
    input  logic            clk,
    input  logic            rst,
    input  logic            tx_start,
    input  fib_pkg::meta_t  tx_meta,
    input  fib_pkg::name_t  tx_name,
    input  fib_pkg::name_t  tx_match,
    output logic            tx_busy,
    output logic            fib_to_spi_data_flag,
    output fib_pkg::byte_t  data_fib_to_spi
);

    localparam int FRAME_BYTES = `FIB_FRAME_BYTES;
    localparam int FRAME_BITS  = FRAME_BYTES * 8;

    logic [FRAME_BITS-1:0] frame_sr;
    logic [4:0]            byte_cnt;
    logic                  load;

    assign load = tx_start && !fib_to_spi_data_flag;

    // Top byte of the shift register is always the one on the bus
    assign data_fib_to_spi = frame_sr[FRAME_BITS-1 -: 8];
    assign tx_busy = fib_to_spi_data_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fib_to_spi_data_flag <= 1'b0;
            byte_cnt             <= '0;
        end else if (load) begin
            fib_to_spi_data_flag <= 1'b1;
            byte_cnt             <= 5'(FRAME_BYTES);
        end else if (fib_to_spi_data_flag) begin
            byte_cnt <= byte_cnt - 5'd1;
            // Last byte is on the bus now
            if (byte_cnt == 5'd1) begin
                fib_to_spi_data_flag <= 1'b0;
            end
        end
    end

    // Metadata first, then full name, then matched prefix, all MSB first
    always_ff @(posedge clk) begin
        if (load) begin
            frame_sr <= {tx_meta, tx_name, tx_match};
        end else if (fib_to_spi_data_flag) begin
            frame_sr <= frame_sr << 8;
        end
    end

    // A frame never runs past its 17 bytes
    a_frame_len: assert property (@(posedge clk) disable iff (rst)
        $rose(fib_to_spi_data_flag) |-> ##FRAME_BYTES !fib_to_spi_data_flag);

endmodule

/* fib_table.sv */
`timescale 1ns/10ps

module fib_table (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx_valid,
    input  fib_pkg::byte_t  data_spi_to_fib,
    input  logic            fib_out,
    input  fib_pkg::name_t  pit_in_prefix,
    input  fib_pkg::meta_t  pit_in_metadata,
    output logic            prefix_ready,
    output fib_pkg::name_t  pit_out_prefix,
    output fib_pkg::meta_t  pit_out_metadata,
    output logic            fib_to_spi_data_flag,
    output fib_pkg::byte_t  data_fib_to_spi
);

    // Install side
    logic           inst_req;
    fib_pkg::plen_t inst_len;
    fib_pkg::hash_t inst_hash;
    logic           inst_gnt;

    // Lookup side
    logic           rd_req;
    fib_pkg::plen_t rd_len;
    fib_pkg::hash_t rd_hash;
    logic           rd_gnt;

    // Shared bitmap port
    logic           mem_we;
    logic           mem_re;
    fib_pkg::plen_t mem_len;
    fib_pkg::hash_t mem_hash;
    logic           mem_rd_valid;
    logic           mem_rd_bit;

    // Lookup result to frame sender
    logic           tx_start;
    fib_pkg::meta_t tx_meta;
    fib_pkg::name_t tx_name;
    fib_pkg::name_t tx_match;
    logic           tx_busy;

    fib_ingress fib_ingress_inst (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .data_spi_to_fib  (data_spi_to_fib),
        .inst_gnt         (inst_gnt),
        .prefix_ready     (prefix_ready),
        .pit_out_prefix   (pit_out_prefix),
        .pit_out_metadata (pit_out_metadata),
        .inst_req         (inst_req),
        .inst_len         (inst_len),
        .inst_hash        (inst_hash)
    );

    fib_lookup fib_lookup_inst (
        .clk             (clk),
        .rst             (rst),
        .fib_out         (fib_out),
        .pit_in_prefix   (pit_in_prefix),
        .pit_in_metadata (pit_in_metadata),
        .rd_gnt          (rd_gnt),
        .mem_rd_valid    (mem_rd_valid),
        .mem_rd_bit      (mem_rd_bit),
        .tx_busy         (tx_busy),
        .rd_req          (rd_req),
        .rd_len          (rd_len),
        .rd_hash         (rd_hash),
        .tx_start        (tx_start),
        .tx_meta         (tx_meta),
        .tx_name         (tx_name),
        .tx_match        (tx_match)
    );

    fib_spi_tx fib_spi_tx_inst (
        .clk                  (clk),
        .rst                  (rst),
        .tx_start             (tx_start),
        .tx_meta              (tx_meta),
        .tx_name              (tx_name),
        .tx_match             (tx_match),
        .tx_busy              (tx_busy),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

    fib_arbiter fib_arbiter_inst (
        .inst_req  (inst_req),
        .inst_len  (inst_len),
        .inst_hash (inst_hash),
        .rd_req    (rd_req),
        .rd_len    (rd_len),
        .rd_hash   (rd_hash),
        .inst_gnt  (inst_gnt),
        .rd_gnt    (rd_gnt),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_len   (mem_len),
        .mem_hash  (mem_hash)
    );

    fib_bitmap fib_bitmap_inst (
        .clk          (clk),
        .rst          (rst),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .mem_len      (mem_len),
        .mem_hash     (mem_hash),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_bit   (mem_rd_bit)
    );

endmodule

/* tb_fib_table.sv */
`timescale 1ns/10ps
`include "fib_consts.svh"

module tb_fib_table;

    localparam int CLK_PERIOD    = 40;
    localparam int FRAME_BYTES   = `FIB_FRAME_BYTES;
    localparam int NUM_TESTS     = 5;
    localparam int OPS_PER_TEST  = 8;
    localparam int CYCLES_PER_OP = 300;
    // Longest search is 64 probes plus the frame
    localparam int WAIT_CYCLES   = 400;
    localparam int NUM_INTERESTS = 10;

    logic           clk;
    logic           rst;
    logic           rx_valid;
    fib_pkg::byte_t data_spi_to_fib;
    logic           fib_out;
    fib_pkg::name_t pit_in_prefix;
    fib_pkg::meta_t pit_in_metadata;
    logic           prefix_ready;
    fib_pkg::name_t pit_out_prefix;
    fib_pkg::meta_t pit_out_metadata;
    logic           fib_to_spi_data_flag;
    fib_pkg::byte_t data_fib_to_spi;

    // Reference bitmap, one row per prefix length
    bit model_bits [`FIB_LENGTHS][`FIB_SLOTS];

    // Outstanding expectations, oldest first
    logic [8*FRAME_BYTES-1:0] exp_frames [$];
    fib_pkg::name_t           exp_pit_name [$];
    fib_pkg::meta_t           exp_pit_meta [$];

    // Installed names, used to aim lookups at real prefixes
    fib_pkg::name_t inst_names [$];
    int             inst_lens [$];

    logic [8*FRAME_BYTES-1:0] got_frame;
    int frame_cnt;
    int errors = 0;
    int tests_failed = 0;
    int test_start_errors = 0;

    fib_table fib_table_inst (
        .clk                  (clk),
        .rst                  (rst),
        .rx_valid             (rx_valid),
        .data_spi_to_fib      (data_spi_to_fib),
        .fib_out              (fib_out),
        .pit_in_prefix        (pit_in_prefix),
        .pit_in_metadata      (pit_in_metadata),
        .prefix_ready         (prefix_ready),
        .pit_out_prefix       (pit_out_prefix),
        .pit_out_metadata     (pit_out_metadata),
        .fib_to_spi_data_flag (fib_to_spi_data_flag),
        .data_fib_to_spi      (data_fib_to_spi)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Bits below len survive, everything from len up is cleared
    function automatic fib_pkg::name_t ref_mask(fib_pkg::name_t name, int len);
        fib_pkg::name_t r;
        r = '0;
        for (int i = 0; i < len; i++) begin
            r[i] = name[i];
        end
        return r;
    endfunction

    // Six 10-bit slices plus the top four bits, all folded by XOR
    function automatic fib_pkg::hash_t ref_hash(fib_pkg::name_t name, int len);
        fib_pkg::name_t m;
        fib_pkg::hash_t h;
        m = ref_mask(name, len);
        h = '0;
        for (int s = 0; s < 6; s++) begin
            h = h ^ m[s*10 +: 10];
        end
        h = h ^ {6'b0, m[63:60]};
        return h;
    endfunction

    // Expected frame: rewritten metadata, full name, matched prefix
    function automatic logic [8*FRAME_BYTES-1:0] ref_frame(fib_pkg::name_t name,
                                                           fib_pkg::meta_t meta);
        int len;
        fib_pkg::meta_t out_meta;
        len = int'(meta[`FIB_LEN_BITS-1:0]);
        // Walk down until a set bit, length 0 ends the search regardless
        while (len > 0 && !model_bits[len][ref_hash(name, len)]) begin
            len--;
        end
        out_meta = {meta[7:`FIB_LEN_BITS], 6'(len)};
        return {out_meta, name, ref_mask(name, len)};
    endfunction

    // Keeps the first len bits of base, random bits above
    function automatic fib_pkg::name_t extend_name(fib_pkg::name_t base, int len);
        fib_pkg::name_t hi;
        hi = {$urandom, $urandom};
        return ref_mask(base, len) | (hi & ~ref_mask('1, len));
    endfunction

    function automatic fib_pkg::meta_t data_meta(int len);
        return {1'b0, 1'($urandom), 6'(len)};
    endfunction

    function automatic fib_pkg::meta_t lookup_meta(int len);
        return {2'($urandom), 6'(len)};
    endfunction

    task automatic check_name(string sig, fib_pkg::name_t got, fib_pkg::name_t exp_val);
        if (got !== exp_val) begin
            $display("Error: %s = 0x%h, expected 0x%h", sig, got, exp_val);
            errors++;
        end
    endtask

    task automatic check_meta(string sig, fib_pkg::meta_t got, fib_pkg::meta_t exp_val);
        if (got !== exp_val) begin
            $display("Error: %s = 0x%h, expected 0x%h", sig, got, exp_val);
            errors++;
        end
    endtask

    task automatic check_byte(string sig, fib_pkg::byte_t got, fib_pkg::byte_t exp_val);
        if (got !== exp_val) begin
            $display("Error: %s = 0x%h, expected 0x%h", sig, got, exp_val);
            errors++;
        end
    endtask

    // Frame collected, compare byte by byte
    task automatic close_frame();
        logic [8*FRAME_BYTES-1:0] exp_frame;
        if (frame_cnt != FRAME_BYTES) begin
            $display("Frame had %0d flagged bytes instead of %0d", frame_cnt, FRAME_BYTES);
            errors++;
        end
        if (exp_frames.size() == 0) begin
            $display("Frame sent to SPI with no lookup outstanding");
            errors++;
        end else begin
            exp_frame = exp_frames.pop_front();
            for (int b = 0; b < FRAME_BYTES; b++) begin
                check_byte($sformatf("data_fib_to_spi[%0d]", b),
                           got_frame[8*(FRAME_BYTES-1-b) +: 8],
                           exp_frame[8*(FRAME_BYTES-1-b) +: 8]);
            end
        end
    endtask

    // Gathers flagged bytes, the falling flag closes a frame
    always @(posedge clk) begin : frame_monitor
        if (rst) begin
            frame_cnt = 0;
        end else if (fib_to_spi_data_flag) begin
            got_frame = {got_frame[8*FRAME_BYTES-9:0], data_fib_to_spi};
            frame_cnt++;
            if (frame_cnt == FRAME_BYTES + 1) begin
                $display("Frame flag stayed high past %0d bytes", FRAME_BYTES);
                errors++;
            end
        end else if (frame_cnt != 0) begin
            close_frame();
            frame_cnt = 0;
        end
    end

    // Every pulse must match exactly one interest packet
    always @(posedge clk) begin : pit_monitor
        if (!rst && prefix_ready) begin
            if (exp_pit_name.size() == 0) begin
                $display("prefix_ready pulsed with no interest packet outstanding");
                errors++;
            end else begin
                check_name("pit_out_prefix", pit_out_prefix, exp_pit_name.pop_front());
                check_meta("pit_out_metadata", pit_out_metadata, exp_pit_meta.pop_front());
            end
        end
    end

    // Last byte sent, so the model follows the packet now
    task automatic note_packet(fib_pkg::meta_t meta, fib_pkg::name_t name);
        int len;
        len = int'(meta[`FIB_LEN_BITS-1:0]);
        if (meta[`FIB_INTEREST_BIT]) begin
            exp_pit_name.push_back(name);
            exp_pit_meta.push_back(meta);
        end else begin
            model_bits[len][ref_hash(name, len)] = 1'b1;
            inst_names.push_back(name);
            inst_lens.push_back(len);
        end
    endtask

    // Metadata then name MSB first, a lookup may ride on the last byte
    task automatic send_packet(fib_pkg::meta_t meta, fib_pkg::name_t name, bit gaps,
                               bit with_lookup, fib_pkg::name_t lk_name,
                               fib_pkg::meta_t lk_meta);
        for (int i = 0; i <= `FIB_NAME_BYTES; i++) begin
            if (gaps && $urandom_range(0, 3) == 0) begin
                @(negedge clk);
                rx_valid = 1'b0;
            end
            @(negedge clk);
            rx_valid = 1'b1;
            if (i == 0) begin
                data_spi_to_fib = meta;
            end else begin
                data_spi_to_fib = fib_pkg::byte_t'(name >> (8 * (`FIB_NAME_BYTES - i)));
            end
            if (i == `FIB_NAME_BYTES) begin
                note_packet(meta, name);
                // Install wins the first probe cycle, so the new bit is visible
                if (with_lookup) begin
                    fib_out         = 1'b1;
                    pit_in_prefix   = lk_name;
                    pit_in_metadata = lk_meta;
                    exp_frames.push_back(ref_frame(lk_name, lk_meta));
                end
            end
        end
        @(negedge clk);
        rx_valid = 1'b0;
        fib_out  = 1'b0;
    endtask

    // Until every expected frame and PIT event has arrived
    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_frames.size() != 0 || exp_pit_name.size() != 0) && n < WAIT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_frames.size() != 0 || exp_pit_name.size() != 0) begin
            $display("No response within %0d cycles, %0d frames and %0d PIT events missing",
                     WAIT_CYCLES, exp_frames.size(), exp_pit_name.size());
            errors++;
            exp_frames.delete();
            exp_pit_name.delete();
            exp_pit_meta.delete();
        end
        @(negedge clk);
    endtask

    task automatic do_lookup(fib_pkg::name_t name, fib_pkg::meta_t meta);
        @(negedge clk);
        fib_out         = 1'b1;
        pit_in_prefix   = name;
        pit_in_metadata = meta;
        exp_frames.push_back(ref_frame(name, meta));
        @(negedge clk);
        fib_out = 1'b0;
        wait_idle();
    endtask

    task automatic report_test(int num, string label);
        int n;
        n = errors - test_start_errors;
        if (n == 0) begin
            $display("Test %0d %s: ok", num, label);
        end else begin
            $display("Test %0d %s: %0d errors", num, label, n);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    initial begin : stimulus
        fib_pkg::name_t base;
        fib_pkg::name_t name;
        fib_pkg::name_t lk_name;
        fib_pkg::name_t int_names [NUM_INTERESTS];
        fib_pkg::meta_t int_metas [NUM_INTERESTS];
        int len;
        int lk_len;
        int pick;
        int choice;
        void'($urandom(32'h62835a66));
        clk             = 1'b0;
        rst             = 1'b1;
        rx_valid        = 1'b0;
        data_spi_to_fib = '0;
        fib_out         = 1'b0;
        pit_in_prefix   = '0;
        pit_in_metadata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Nothing driven, nothing may come out
        repeat (20) begin
            @(posedge clk);
            if (prefix_ready || fib_to_spi_data_flag) begin
                $display("Output went active after reset with no input driven");
                errors++;
            end
        end
        report_test(1, "idle after reset");

        // Interests with idle gaps between bytes, kept for the lookups after
        for (int i = 0; i < NUM_INTERESTS; i++) begin
            int_metas[i] = {1'b1, 7'($urandom)};
            int_names[i] = {$urandom, $urandom};
            send_packet(int_metas[i], int_names[i], 1'b1, 1'b0, '0, '0);
        end
        wait_idle();
        report_test(2, "interest packets");

        // Interest names at their own lengths, still an empty table
        for (int i = 0; i < NUM_INTERESTS; i++) begin
            do_lookup(int_names[i], lookup_meta(int_metas[i][`FIB_LEN_BITS-1:0]));
        end
        report_test(3, "lookup on empty table");

        // Nested prefixes of one base name
        base = {$urandom, $urandom};
        send_packet(data_meta(8), extend_name(base, 8), 1'b0, 1'b0, '0, '0);
        send_packet(data_meta(17), extend_name(base, 17), 1'b0, 1'b0, '0, '0);
        send_packet(data_meta(33), extend_name(base, 33), 1'b0, 1'b0, '0, '0);
        send_packet(data_meta(47), extend_name(base, 47), 1'b0, 1'b0, '0, '0);
        wait_idle();
        do_lookup(base, lookup_meta(63));
        do_lookup(base, lookup_meta(40));
        do_lookup(base, lookup_meta(20));
        do_lookup(base, lookup_meta(12));
        do_lookup(base, lookup_meta(5));
        do_lookup({$urandom, $urandom}, lookup_meta(63));
        do_lookup({$urandom, $urandom}, lookup_meta(63));
        report_test(4, "longest prefix match");

        // Installs and lookups in the same cycle, arbiter contends
        for (int i = 0; i < 24; i++) begin
            len    = $urandom_range(0, 63);
            name   = {$urandom, $urandom};
            choice = $urandom_range(0, 3);
            pick   = $urandom_range(0, inst_names.size());
            if (choice == 0) begin
                // Aimed at the prefix being installed right now
                lk_len  = $urandom_range(len, 63);
                lk_name = extend_name(name, len);
            end else if (pick < inst_names.size()) begin
                lk_len  = $urandom_range(inst_lens[pick], 63);
                lk_name = extend_name(inst_names[pick], inst_lens[pick]);
            end else begin
                lk_len  = $urandom_range(0, 63);
                lk_name = {$urandom, $urandom};
            end
            if (choice == 3) begin
                do_lookup(lk_name, lookup_meta(lk_len));
            end else begin
                send_packet(data_meta(len), name, 1'b1, choice <= 1, lk_name,
                            lookup_meta(lk_len));
                wait_idle();
            end
        end
        report_test(5, "mixed installs and lookups");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Budget of 300 cycles for each of 8 operations per test
    initial begin : watchdog
        #(NUM_TESTS * OPS_PER_TEST * CYCLES_PER_OP * CLK_PERIOD);
        $display("Watchdog expired with tests still running");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
fib_pkg.sv
fib_arbiter.sv
fib_bitmap.sv
fib_ingress.sv
fib_lookup.sv
fib_spi_tx.sv
fib_table.sv
tb_fib_table.sv

/* Makefile */
# Verilator build and run of the FIB testbench

TOP = tb_fib_table

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Testbench failed" sim.log

obj_dir/V$(TOP): list.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall --top-module fib_table -f list.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run lint clean
